// ==== tcp_proto_pkg.sv ====
package tcp_proto_pkg;

    // --------------------
    // Field widths
    // --------------------
    localparam int SEQ_W   = 32;
    localparam int LEN_W   = 16;
    localparam int FLAGS_W = 8;

    typedef logic [SEQ_W-1:0]   seq_t;        // Sequence or ack number
    typedef logic [LEN_W-1:0]   len_t;        // Payload length in bytes
    typedef logic [FLAGS_W-1:0] tcp_flags_t;  // Flag byte as on the wire

    // Bit positions inside tcp_flags_t
    localparam int FLAG_FIN = 0;
    localparam int FLAG_SYN = 1;
    localparam int FLAG_RST = 2;
    localparam int FLAG_PSH = 3;
    localparam int FLAG_ACK = 4;

    // --------------------
    // Segment descriptors
    // --------------------
    typedef struct packed {
        seq_t       seq;
        seq_t       ack;
        tcp_flags_t flags;
        len_t       window;       // Our receive window
        len_t       payload_len;
    } tcp_seg_t;                  // Outgoing segment, to the sender

    typedef struct packed {
        seq_t       seq;
        seq_t       ack;
        tcp_flags_t flags;
        len_t       payload_len;
    } tcp_meta_t;                 // Parsed incoming segment

endpackage

// ==== tcp_ctrl_pkg.sv ====
package tcp_ctrl_pkg;

    // Connection states
    typedef enum logic [3:0] {
        ST_CLOSED,
        ST_SYN_SENT,
        ST_ESTABLISHED,
        ST_FIN_WAIT_1,
        ST_FIN_WAIT_2,
        ST_TIME_WAIT,
        ST_CLOSE_WAIT,
        ST_LAST_ACK
    } tcp_state_e;

    // Application opcodes
    typedef enum logic [7:0] {
        CMD_CONNECT = 8'h01,
        CMD_CLOSE   = 8'h02,
        CMD_SEND    = 8'h03
    } tcp_cmd_e;

    // Request from a producer to the tx arbiter
    typedef struct packed {
        tcp_proto_pkg::tcp_flags_t flags;
        tcp_proto_pkg::len_t       payload_len;
        logic                      retx;         // Resend, reuse last seq
    } seg_req_t;

endpackage

// ==== tcp_conn_fsm.sv ====
`timescale 1ns/1ps

module tcp_conn_fsm #(
    parameter int                  TIMEOUT_CYCLES   = 1000,
    parameter int                  TIME_WAIT_CYCLES = 2000,
    parameter int                  MAX_RETRIES      = 3,
    parameter tcp_proto_pkg::seq_t ISN              = 32'h1234_5678
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  tcp_ctrl_pkg::tcp_cmd_e   cmd_op,
    input  tcp_proto_pkg::len_t      cmd_len,
    output logic                     cmd_ready,
    input  logic                     meta_valid,
    input  tcp_proto_pkg::tcp_meta_t meta,
    input  tcp_proto_pkg::seq_t      snd_nxt,
    input  logic                     data_pending,
    output logic                     send_go,
    output tcp_proto_pkg::len_t      send_len,
    output logic                     rcv_init,
    output logic                     rcv_fin,
    output logic                     rcv_data,
    output logic                     req,
    output tcp_ctrl_pkg::seg_req_t   req_seg,
    input  logic                     grant,
    output tcp_ctrl_pkg::tcp_state_e state
);
    import tcp_proto_pkg::*;
    import tcp_ctrl_pkg::*;

    localparam int TMR_MAX = (TIMEOUT_CYCLES > TIME_WAIT_CYCLES) ? TIMEOUT_CYCLES
                                                                 : TIME_WAIT_CYCLES;
    localparam int TMR_W   = $clog2(TMR_MAX + 1);
    localparam int RTY_W   = $clog2(MAX_RETRIES + 2);

    localparam tcp_flags_t F_ACK     = tcp_flags_t'(1 << FLAG_ACK);
    localparam tcp_flags_t F_SYN     = tcp_flags_t'(1 << FLAG_SYN);
    localparam tcp_flags_t F_FIN_ACK = tcp_flags_t'((1 << FLAG_FIN) | (1 << FLAG_ACK));

    logic [TMR_W-1:0] timer;     // Shared by retransmit and TIME_WAIT
    logic             tmr_on;
    logic [RTY_W-1:0] retries;
    logic             expired;
    logic             give_up;
    logic             cmd_take;
    logic             peer_rst;
    logic             ack_ok;

    function automatic seg_req_t mk_req(input tcp_flags_t flags);
        return '{flags: flags, payload_len: '0, retx: 1'b0};
    endfunction

    // --------------------
    // Decode
    // --------------------
    assign cmd_take = cmd_valid && cmd_ready;
    assign peer_rst = meta_valid && meta.flags[FLAG_RST] && (state != ST_CLOSED);
    assign ack_ok   = meta_valid && meta.flags[FLAG_ACK] && (meta.ack == snd_nxt);
    assign expired  = tmr_on && (timer == '0);
    assign give_up  = (retries == RTY_W'(MAX_RETRIES));

    assign rcv_init = ack_ok && meta.flags[FLAG_SYN] && !meta.flags[FLAG_RST]
                      && (state == ST_SYN_SENT);
    assign rcv_fin  = meta_valid && meta.flags[FLAG_FIN] && !meta.flags[FLAG_RST]
                      && (state == ST_ESTABLISHED || state == ST_FIN_WAIT_2);
    assign rcv_data = meta_valid && !meta.flags[FLAG_FIN] && !meta.flags[FLAG_RST]
                      && (meta.payload_len != '0) && (state == ST_ESTABLISHED);

    assign send_go  = cmd_take && (cmd_op == CMD_SEND) && (state == ST_ESTABLISHED);
    assign send_len = cmd_len;

    always_comb begin
        case (state)
            ST_CLOSED:      cmd_ready = 1'b1;                  // CONNECT only
            ST_ESTABLISHED: cmd_ready = !req && !data_pending; // SEND or CLOSE
            ST_CLOSE_WAIT:  cmd_ready = 1'b1;                  // CLOSE only
            default:        cmd_ready = 1'b0;
        endcase
    end

    // --------------------
    // State, timer, retries
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_CLOSED;
            req     <= 1'b0;
            req_seg <= '0;
            timer   <= '0;
            tmr_on  <= 1'b0;
            retries <= '0;
        end else begin
            if (grant) begin
                req <= 1'b0;
                if (req_seg.flags[FLAG_SYN] || req_seg.flags[FLAG_FIN]) begin
                    timer  <= TMR_W'(TIMEOUT_CYCLES - 1);   // Wait for the peer answer
                    tmr_on <= 1'b1;
                end else if (state == ST_TIME_WAIT) begin
                    timer  <= TMR_W'(TIME_WAIT_CYCLES - 1); // Final ACK is out
                    tmr_on <= 1'b1;
                end
            end else if (tmr_on && timer != '0) begin
                timer <= timer - 1'b1;
            end

            // Retransmit of SYN or FIN|ACK, req_seg still holds the last one
            if (expired && (state == ST_SYN_SENT || state == ST_FIN_WAIT_1
                            || state == ST_LAST_ACK)) begin
                tmr_on <= 1'b0;
                if (give_up) begin
                    state <= ST_CLOSED;
                    req   <= 1'b0;
                end else begin
                    retries      <= retries + 1'b1;
                    req          <= 1'b1;
                    req_seg.retx <= 1'b1;
                end
            end

            case (state)
                ST_CLOSED: begin
                    if (cmd_take && cmd_op == CMD_CONNECT) begin
                        state   <= ST_SYN_SENT;
                        req     <= 1'b1;
                        req_seg <= mk_req(F_SYN);
                        retries <= '0;
                    end
                end
                ST_SYN_SENT: begin
                    if (rcv_init) begin             // Third leg of the handshake
                        state   <= ST_ESTABLISHED;
                        req     <= 1'b1;
                        req_seg <= mk_req(F_ACK);
                        tmr_on  <= 1'b0;
                    end
                end
                ST_ESTABLISHED: begin
                    if (rcv_fin) begin              // Passive close
                        state   <= ST_CLOSE_WAIT;
                        req     <= 1'b1;
                        req_seg <= mk_req(F_ACK);
                    end else if (cmd_take && cmd_op == CMD_CLOSE) begin
                        state   <= ST_FIN_WAIT_1;
                        req     <= 1'b1;
                        req_seg <= mk_req(F_FIN_ACK);
                        retries <= '0;
                    end
                end
                ST_FIN_WAIT_1: begin
                    if (ack_ok) begin               // Our FIN is acked
                        state  <= ST_FIN_WAIT_2;
                        tmr_on <= 1'b0;
                    end
                end
                ST_FIN_WAIT_2: begin
                    if (rcv_fin) begin
                        state   <= ST_TIME_WAIT;
                        req     <= 1'b1;
                        req_seg <= mk_req(F_ACK);
                        tmr_on  <= 1'b0;
                    end
                end
                ST_TIME_WAIT: begin
                    if (expired) begin
                        state  <= ST_CLOSED;
                        tmr_on <= 1'b0;
                    end
                end
                ST_CLOSE_WAIT: begin
                    // A still pending ACK merges into the FIN|ACK
                    if (cmd_take && cmd_op == CMD_CLOSE) begin
                        state   <= ST_LAST_ACK;
                        req     <= 1'b1;
                        req_seg <= mk_req(F_FIN_ACK);
                        retries <= '0;
                        tmr_on  <= 1'b0;
                    end
                end
                ST_LAST_ACK: begin
                    if (ack_ok) begin
                        state  <= ST_CLOSED;
                        req    <= 1'b0;
                        tmr_on <= 1'b0;
                    end
                end
                default: state <= ST_CLOSED;
            endcase

            if (peer_rst) begin                     // Drop the connection
                state  <= ST_CLOSED;
                req    <= 1'b0;
                tmr_on <= 1'b0;
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {ST_CLOSED, ST_SYN_SENT, ST_ESTABLISHED, ST_FIN_WAIT_1,
                      ST_FIN_WAIT_2, ST_TIME_WAIT, ST_CLOSE_WAIT, ST_LAST_ACK});

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req && !grant |=> req || state == ST_CLOSED);

    // SYN-ACK only matches once the arbiter has stamped our SYN
    a_synack_isn: assert property (@(posedge clk) disable iff (!rst_n)
        rcv_init |-> snd_nxt == ISN + seq_t'(1));

endmodule

// ==== tcp_rx_acker.sv ====
`timescale 1ns/1ps

module tcp_rx_acker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     meta_valid,
    input  tcp_proto_pkg::tcp_meta_t meta,
    input  logic                     rcv_init,
    input  logic                     rcv_fin,
    input  logic                     rcv_data,
    output tcp_proto_pkg::seq_t      rcv_nxt,
    output logic                     req,
    output tcp_ctrl_pkg::seg_req_t   req_seg,
    input  logic                     grant
);
    import tcp_proto_pkg::*;
    import tcp_ctrl_pkg::*;

    logic in_order;

    assign in_order = meta_valid && (meta.seq == rcv_nxt);

    // Pure ACK, the arbiter stamps ack from rcv_nxt at grant time
    assign req_seg = '{flags: tcp_flags_t'(1 << FLAG_ACK), payload_len: '0, retx: 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rcv_nxt <= '0;
            req     <= 1'b0;
        end else begin
            if (grant) req <= 1'b0;
            if (rcv_init) begin
                rcv_nxt <= meta.seq + seq_t'(1);         // Peer SYN takes one number
            end else if (rcv_fin) begin
                rcv_nxt <= rcv_nxt + seq_t'(1);          // So does its FIN
            end else if (rcv_data) begin
                req <= 1'b1;                             // Dup ACK when out of order
                if (in_order) rcv_nxt <= rcv_nxt + seq_t'(meta.payload_len);
            end
        end
    end

endmodule

// ==== tcp_data_tx.sv ====
`timescale 1ns/1ps

module tcp_data_tx #(
    parameter int MSS = 1460
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   send_go,
    input  tcp_proto_pkg::len_t    send_len,
    output logic                   data_pending,
    output logic                   req,
    output tcp_ctrl_pkg::seg_req_t req_seg,
    input  logic                   grant
);
    import tcp_proto_pkg::*;
    import tcp_ctrl_pkg::*;

    localparam tcp_flags_t F_ACK     = tcp_flags_t'(1 << FLAG_ACK);
    localparam tcp_flags_t F_ACK_PSH = tcp_flags_t'((1 << FLAG_ACK) | (1 << FLAG_PSH));

    len_t remaining;   // Bytes not yet granted
    len_t seg_len;
    logic last_seg;

    assign last_seg     = (remaining <= len_t'(MSS));
    assign seg_len      = last_seg ? remaining : len_t'(MSS);
    assign data_pending = (remaining != '0);

    // PSH marks the tail of the send command
    assign req_seg = '{flags:       last_seg ? F_ACK_PSH : F_ACK,
                       payload_len: seg_len,
                       retx:        1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
            req       <= 1'b0;
        end else begin
            if (send_go) remaining <= send_len;
            else if (grant) remaining <= remaining - seg_len;

            if (grant) req <= 1'b0;              // Drop for one cycle between segments
            else if (data_pending) req <= 1'b1;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        send_go |-> !data_pending);

endmodule

// ==== tcp_tx_arbiter.sv ====
`timescale 1ns/1ps

module tcp_tx_arbiter #(
    parameter tcp_proto_pkg::seq_t ISN = 32'h1234_5678
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fsm_req,
    input  tcp_ctrl_pkg::seg_req_t  fsm_seg,
    output logic                    fsm_grant,
    input  logic                    ack_req,
    input  tcp_ctrl_pkg::seg_req_t  ack_seg,
    output logic                    ack_grant,
    input  logic                    data_req,
    input  tcp_ctrl_pkg::seg_req_t  data_seg,
    output logic                    data_grant,
    input  tcp_proto_pkg::seq_t     rcv_nxt,
    input  tcp_proto_pkg::len_t     rcv_window,
    input  logic                    closed,
    output tcp_proto_pkg::seq_t     snd_nxt,
    output logic                    sender_start,
    output tcp_proto_pkg::tcp_seg_t sender_seg,
    input  logic                    sender_busy
);
    import tcp_proto_pkg::*;
    import tcp_ctrl_pkg::*;

    logic     active;      // Low means idle and free to grant
    logic     any_grant;
    seg_req_t gnt_seg;
    seq_t     advance;

    assign any_grant = fsm_grant | ack_grant | data_grant;

    always_comb begin
        if (fsm_grant) gnt_seg = fsm_seg;
        else if (ack_grant) gnt_seg = ack_seg;
        else gnt_seg = data_seg;
    end

    // SYN and FIN each use one sequence number
    assign advance = seq_t'(gnt_seg.payload_len) + seq_t'(gnt_seg.flags[FLAG_SYN])
                     + seq_t'(gnt_seg.flags[FLAG_FIN]);

    // --------------------
    // Grant and start/busy
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            fsm_grant    <= 1'b0;
            ack_grant    <= 1'b0;
            data_grant   <= 1'b0;
            sender_start <= 1'b0;
            snd_nxt      <= ISN;
        end else begin
            fsm_grant    <= 1'b0;
            ack_grant    <= 1'b0;
            data_grant   <= 1'b0;
            sender_start <= any_grant;          // Start follows the grant
            if (!active) begin
                active <= fsm_req | ack_req | data_req;
                if (fsm_req) fsm_grant <= 1'b1; // Fixed priority
                else if (ack_req) ack_grant <= 1'b1;
                else if (data_req) data_grant <= 1'b1;
            end else if (!any_grant && !sender_start && !sender_busy) begin
                active <= 1'b0;                 // Sender done
            end

            if (closed) snd_nxt <= ISN;
            else if (any_grant && !gnt_seg.retx) snd_nxt <= snd_nxt + advance;
        end
    end

    // Segment stamp, held until the next start
    always_ff @(posedge clk) begin
        if (any_grant) begin
            sender_seg.seq         <= gnt_seg.retx ? snd_nxt - seq_t'(1) : snd_nxt;
            sender_seg.ack         <= rcv_nxt;
            sender_seg.flags       <= gnt_seg.flags;
            sender_seg.window      <= rcv_window;
            sender_seg.payload_len <= gnt_seg.payload_len;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({fsm_grant, ack_grant, data_grant}));

    a_start_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        sender_start |-> $past(any_grant) && !$past(active, 2));

endmodule

// ==== tcp_engine.sv ====
`timescale 1ns/1ps

module tcp_engine #(
    parameter int                  TIMEOUT_CYCLES   = 1000,
    parameter int                  TIME_WAIT_CYCLES = 2000,
    parameter int                  MAX_RETRIES      = 3,
    parameter tcp_proto_pkg::seq_t ISN              = 32'h1234_5678,
    parameter int                  MSS              = 1460
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  tcp_ctrl_pkg::tcp_cmd_e   cmd_op,
    input  tcp_proto_pkg::len_t      cmd_len,
    output logic                     cmd_ready,
    input  logic                     meta_valid,
    input  tcp_proto_pkg::tcp_meta_t meta,
    input  tcp_proto_pkg::len_t      rcv_window,
    output logic                     sender_start,
    output tcp_proto_pkg::tcp_seg_t  sender_seg,
    input  logic                     sender_busy,
    output tcp_ctrl_pkg::tcp_state_e conn_state
);
    import tcp_proto_pkg::*;
    import tcp_ctrl_pkg::*;

    seq_t     snd_nxt;
    seq_t     rcv_nxt;
    len_t     send_len;
    logic     send_go;
    logic     data_pending;
    logic     rcv_init;
    logic     rcv_fin;
    logic     rcv_data;
    logic     fsm_req;
    logic     fsm_grant;
    logic     ack_req;
    logic     ack_grant;
    logic     data_req;
    logic     data_grant;
    seg_req_t fsm_seg;
    seg_req_t ack_seg;
    seg_req_t data_seg;

    // --------------------
    // Producers
    // --------------------
    tcp_conn_fsm #(
        .TIMEOUT_CYCLES  (TIMEOUT_CYCLES),
        .TIME_WAIT_CYCLES(TIME_WAIT_CYCLES),
        .MAX_RETRIES     (MAX_RETRIES),
        .ISN             (ISN)
    ) conn_fsm_i (
        .clk, .rst_n,
        .cmd_valid, .cmd_op, .cmd_len, .cmd_ready,
        .meta_valid, .meta,
        .snd_nxt, .data_pending,
        .send_go, .send_len,
        .rcv_init, .rcv_fin, .rcv_data,
        .req(fsm_req), .req_seg(fsm_seg), .grant(fsm_grant),
        .state(conn_state)
    );

    tcp_rx_acker rx_acker_i (
        .clk, .rst_n,
        .meta_valid, .meta,
        .rcv_init, .rcv_fin, .rcv_data,
        .rcv_nxt,
        .req(ack_req), .req_seg(ack_seg), .grant(ack_grant)
    );

    tcp_data_tx #(.MSS(MSS)) data_tx_i (
        .clk, .rst_n,
        .send_go, .send_len, .data_pending,
        .req(data_req), .req_seg(data_seg), .grant(data_grant)
    );

    // Shared sender port
    tcp_tx_arbiter #(.ISN(ISN)) tx_arbiter_i (
        .clk, .rst_n,
        .fsm_req, .fsm_seg, .fsm_grant,
        .ack_req, .ack_seg, .ack_grant,
        .data_req, .data_seg, .data_grant,
        .rcv_nxt, .rcv_window,
        .closed(conn_state == ST_CLOSED),
        .snd_nxt,
        .sender_start, .sender_seg, .sender_busy
    );

endmodule

// ==== tcp_engine_tb.sv ====
`timescale 1ns/1ps

module tcp_engine_tb;
    import tcp_proto_pkg::*;
    import tcp_ctrl_pkg::*;

    localparam int          CLK_PERIOD       = 100;
    localparam int          TIMEOUT_CYCLES   = 20;
    localparam int          TIME_WAIT_CYCLES = 30;
    localparam int          MAX_RETRIES      = 2;
    localparam int          MSS              = 64;
    localparam seq_t        ISN              = 32'h1000_0400;
    localparam len_t        WINDOW           = 16'h2000;
    localparam logic [31:0] SEED             = 32'h022d_578b;

    localparam int SEG_WAIT        = 2 * TIMEOUT_CYCLES + 20;  // Longest gap to a segment
    localparam int TEST_CYCLES     = (MAX_RETRIES + 1) * SEG_WAIT + TIME_WAIT_CYCLES + 100;
    localparam int WATCHDOG_CYCLES = 5 + 6 * TEST_CYCLES + 200;

    localparam tcp_flags_t F_FIN = tcp_flags_t'(1 << FLAG_FIN);
    localparam tcp_flags_t F_SYN = tcp_flags_t'(1 << FLAG_SYN);
    localparam tcp_flags_t F_RST = tcp_flags_t'(1 << FLAG_RST);
    localparam tcp_flags_t F_PSH = tcp_flags_t'(1 << FLAG_PSH);
    localparam tcp_flags_t F_ACK = tcp_flags_t'(1 << FLAG_ACK);

    logic       clk;
    logic       rst_n;
    logic       cmd_valid;
    tcp_cmd_e   cmd_op;
    len_t       cmd_len;
    logic       cmd_ready;
    logic       meta_valid;
    tcp_meta_t  meta;
    len_t       rcv_window;
    logic       sender_start;
    tcp_seg_t   sender_seg;
    logic       sender_busy;
    tcp_state_e conn_state;

    tcp_seg_t seg_q[$];    // Segments seen on the sender port
    int       busy_left;
    seq_t     snd_nxt_m;   // Model of our next sequence number
    seq_t     rcv_nxt_m;   // Model of the peer's next sequence number

    tcp_engine #(
        .TIMEOUT_CYCLES  (TIMEOUT_CYCLES),
        .TIME_WAIT_CYCLES(TIME_WAIT_CYCLES),
        .MAX_RETRIES     (MAX_RETRIES),
        .ISN             (ISN),
        .MSS             (MSS)
    ) dut_i (
        .clk, .rst_n,
        .cmd_valid, .cmd_op, .cmd_len, .cmd_ready,
        .meta_valid, .meta, .rcv_window,
        .sender_start, .sender_seg, .sender_busy,
        .conn_state
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Sender model
    // --------------------
    always @(negedge clk) begin
        if (sender_start) begin
            seg_q.push_back(sender_seg);      // Stamp is stable after start
            busy_left = 3;
        end else if (busy_left != 0) begin
            busy_left--;
        end
        sender_busy = (busy_left != 0);       // High before the next edge
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic string seg_str(input tcp_seg_t s);
        return $sformatf("seq=%h ack=%h flags=%h win=%h len=%0d",
                         s.seq, s.ack, s.flags, s.window, s.payload_len);
    endfunction

    function automatic tcp_seg_t make_seg(input seq_t seq, input seq_t ack,
                                          input tcp_flags_t flags, input len_t len);
        return '{seq: seq, ack: ack, flags: flags, window: WINDOW, payload_len: len};
    endfunction

    task automatic check_seg(input string name, input tcp_seg_t exp, input tcp_seg_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %s, actual %s", name, seg_str(exp), seg_str(act));
            abort_run();
        end
    endtask

    task automatic check_state(input string name, input tcp_state_e exp);
        if (conn_state !== exp) begin
            $display("Fail %s: expected %s, actual %s", name, exp.name(), conn_state.name());
            abort_run();
        end
    endtask

    task automatic check_ready(input string name, input logic exp);
        if (cmd_ready !== exp) begin
            $display("Fail %s: expected cmd_ready=%b, actual cmd_ready=%b", name, exp, cmd_ready);
            abort_run();
        end
    endtask

    // Queue only changes on the falling edge, so poll on the rising one
    task automatic expect_seg(input string name, input tcp_seg_t exp);
        int       waited;
        tcp_seg_t act;
        waited = 0;
        while (seg_q.size() == 0) begin
            @(posedge clk);
            waited++;
            if (waited > SEG_WAIT) begin
                $display("%s: no segment from the DUT within %0d cycles", name, SEG_WAIT);
                abort_run();
            end
        end
        act = seg_q.pop_front();
        check_seg(name, exp, act);
    endtask

    task automatic wait_state(input string name, input tcp_state_e exp);
        int waited;
        waited = 0;
        while (conn_state != exp && waited < TEST_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        check_state(name, exp);               // Reports the state it got stuck in
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) @(posedge clk);
        if (seg_q.size() != 0) begin
            $display("%s: DUT sent %0d unexpected segment(s)", name, seg_q.size());
            abort_run();
        end
    endtask

    task automatic issue_cmd(input string name, input tcp_cmd_e op, input len_t len);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            if (waited == TEST_CYCLES) begin
                $display("%s: cmd_ready stayed low for %0d cycles", name, waited);
                abort_run();
            end
            @(negedge clk);
            waited++;
        end
        cmd_valid = 1'b1;                     // Taken on the next rising edge
        cmd_op    = op;
        cmd_len   = len;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // One-cycle metadata strobe from the peer
    task automatic peer_seg(input tcp_flags_t flags, input seq_t seq, input seq_t ack,
                            input len_t len);
        @(negedge clk);
        meta_valid = 1'b1;
        meta       = '{seq: seq, ack: ack, flags: flags, payload_len: len};
        @(negedge clk);
        meta_valid = 1'b0;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_syn_retry();
        check_ready("syn_retry", 1'b1);       // Closed takes CONNECT
        issue_cmd("syn_retry", CMD_CONNECT, '0);
        check_state("syn_retry", ST_SYN_SENT);
        check_ready("syn_retry", 1'b0);
        repeat (MAX_RETRIES + 1) begin
            expect_seg("syn_retry", make_seg(ISN, rcv_nxt_m, F_SYN, '0)); // Same seq each time
        end
        wait_state("syn_retry", ST_CLOSED);
        expect_quiet("syn_retry", SEG_WAIT);
        snd_nxt_m = ISN;
    endtask

    task automatic test_connect(input string name);
        seq_t peer_isn;
        peer_isn = $urandom;
        issue_cmd(name, CMD_CONNECT, '0);
        expect_seg(name, make_seg(snd_nxt_m, rcv_nxt_m, F_SYN, '0));
        snd_nxt_m = snd_nxt_m + 1;            // SYN takes one number
        peer_seg(F_SYN | F_ACK, peer_isn, snd_nxt_m, '0);
        rcv_nxt_m = peer_isn + 1;
        expect_seg(name, make_seg(snd_nxt_m, rcv_nxt_m, F_ACK, '0));
        check_state(name, ST_ESTABLISHED);
    endtask

    task automatic test_send();
        len_t       total;
        len_t       rem;
        len_t       seg_len;
        tcp_flags_t flags;
        total = len_t'(1 + $urandom % (4 * MSS));
        issue_cmd("send", CMD_SEND, total);
        check_ready("send", 1'b0);            // Busy with the data
        rem = total;
        while (rem != 0) begin
            seg_len = (rem > len_t'(MSS)) ? len_t'(MSS) : rem;
            flags   = (rem > len_t'(MSS)) ? F_ACK : (F_ACK | F_PSH);  // PSH on the tail
            expect_seg("send", make_seg(snd_nxt_m, rcv_nxt_m, flags, seg_len));
            snd_nxt_m = snd_nxt_m + seq_t'(seg_len);
            rem       = rem - seg_len;
        end
        expect_quiet("send", 10);
        check_state("send", ST_ESTABLISHED);
        check_ready("send", 1'b1);
    endtask

    task automatic test_receive();
        len_t n;
        seq_t gap;
        n = len_t'(1 + $urandom % 100);
        peer_seg(F_ACK, rcv_nxt_m, snd_nxt_m, n);
        rcv_nxt_m = rcv_nxt_m + seq_t'(n);    // In order, ack moves on
        expect_seg("receive", make_seg(snd_nxt_m, rcv_nxt_m, F_ACK, '0));
        gap = seq_t'(1 + $urandom % 1000);
        peer_seg(F_ACK | F_PSH, rcv_nxt_m + gap, snd_nxt_m, n);
        expect_seg("receive", make_seg(snd_nxt_m, rcv_nxt_m, F_ACK, '0)); // Duplicate ACK
        check_state("receive", ST_ESTABLISHED);
    endtask

    task automatic test_active_close();
        issue_cmd("active_close", CMD_CLOSE, '0);
        expect_seg("active_close", make_seg(snd_nxt_m, rcv_nxt_m, F_FIN | F_ACK, '0));
        snd_nxt_m = snd_nxt_m + 1;
        check_state("active_close", ST_FIN_WAIT_1);
        check_ready("active_close", 1'b0);
        peer_seg(F_ACK, rcv_nxt_m, snd_nxt_m, '0);
        wait_state("active_close", ST_FIN_WAIT_2);
        peer_seg(F_FIN | F_ACK, rcv_nxt_m, snd_nxt_m, '0);
        rcv_nxt_m = rcv_nxt_m + 1;            // Peer FIN takes one number
        expect_seg("active_close", make_seg(snd_nxt_m, rcv_nxt_m, F_ACK, '0));
        check_state("active_close", ST_TIME_WAIT);
        wait_state("active_close", ST_CLOSED);
        snd_nxt_m = ISN;
    endtask

    task automatic test_passive_close_rst();
        test_connect("passive_close");
        peer_seg(F_FIN | F_ACK, rcv_nxt_m, snd_nxt_m, '0);
        rcv_nxt_m = rcv_nxt_m + 1;
        expect_seg("passive_close", make_seg(snd_nxt_m, rcv_nxt_m, F_ACK, '0));
        check_state("passive_close", ST_CLOSE_WAIT);
        check_ready("passive_close", 1'b1);   // CLOSE_WAIT takes CLOSE
        issue_cmd("passive_close", CMD_CLOSE, '0);
        expect_seg("passive_close", make_seg(snd_nxt_m, rcv_nxt_m, F_FIN | F_ACK, '0));
        snd_nxt_m = snd_nxt_m + 1;
        check_state("passive_close", ST_LAST_ACK);
        peer_seg(F_ACK, rcv_nxt_m, snd_nxt_m, '0);
        wait_state("passive_close", ST_CLOSED);
        snd_nxt_m = ISN;
        test_connect("reset");
        peer_seg(F_RST | F_ACK, rcv_nxt_m, snd_nxt_m, '0);   // Drop the connection
        wait_state("reset", ST_CLOSED);
        snd_nxt_m = ISN;
        expect_quiet("reset", 10);
    endtask

    // --------------------
    // Run
    // --------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = CMD_CONNECT;
        cmd_len    = '0;
        meta_valid = 1'b0;
        meta       = '0;
        rcv_window = WINDOW;
        sender_busy = 1'b0;
        busy_left  = 0;
        snd_nxt_m  = ISN;
        rcv_nxt_m  = '0;                      // Acker resets to zero
        void'($urandom(SEED));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_syn_retry();
        test_connect("connect");
        test_send();
        test_receive();
        test_active_close();
        test_passive_close_rst();

        $display("test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// ==== tcp_engine.f ====
tcp_proto_pkg.sv
tcp_ctrl_pkg.sv
tcp_conn_fsm.sv
tcp_rx_acker.sv
tcp_data_tx.sv
tcp_tx_arbiter.sv
tcp_engine.sv
tcp_engine_tb.sv

// ==== Bender.yml ====
package:
  name: tcp_engine

sources:
  - tcp_proto_pkg.sv
  - tcp_ctrl_pkg.sv
  - tcp_conn_fsm.sv
  - tcp_rx_acker.sv
  - tcp_data_tx.sv
  - tcp_tx_arbiter.sv
  - tcp_engine.sv
  - target: simulation
    files:
      - tcp_engine_tb.sv
